// File: common/accumPkg.sv
`default_nettype none

package accumPkg;

	// FP16 field widths
	localparam int FP_EXP_W = 5;
	localparam int FP_MAN_W = 10;
	localparam int FP_W = 16;
	localparam int FP_BIAS = 15;

	// Guard, round and sticky below the stored mantissa
	localparam int FP_GRS_W = 3;
	localparam int FP_EXT_W = 1 + FP_MAN_W + FP_GRS_W; // Hidden bit on top
	localparam int FP_SHIFT_W = $clog2(FP_EXT_W);

	localparam int ADD_LATENCY = 8; // Operand to result, fixed by fpAdder stages
	localparam int DEFAULT_ELEM_COUNT = 8;

	typedef struct packed {
		logic sign;
		logic [FP_EXP_W-1:0] exp;
		logic [FP_MAN_W-1:0] man;
	} fpFields_s;

	// Raw view orders magnitudes, field view feeds the datapath
	typedef union packed {
		logic [FP_W-1:0] raw;
		fpFields_s f;
	} fpHalf_u;

endpackage

`default_nettype wire

// File: fpadd/fpAlign.sv
`timescale 1ns/1ps
`default_nettype none

module fpAlign
	import accumPkg::*;
(
	input fpHalf_u a,
	input fpHalf_u b,
	output fpHalf_u larger,
	output logic [FP_EXT_W-1:0] smallMan,
	output logic bSwapped
);

	fpHalf_u aClean;
	fpHalf_u bClean;
	fpHalf_u smaller;
	logic [FP_EXP_W-1:0] expDiff;
	logic [FP_EXT_W-1:0] unshifted;
	logic [FP_EXT_W-1:0] coarse;
	logic [FP_EXT_W-1:0] fine;
	logic coarseLost;
	logic fineLost;

	// Zero exponent counts as zero, no subnormals
	always_comb begin
		aClean = a;
		bClean = b;
		if (a.f.exp == '0)
			aClean.f.man = '0;
		if (b.f.exp == '0)
			bClean.f.man = '0;
	end

	// Exponent sits above mantissa so the raw bits compare as magnitudes
	assign bSwapped = aClean.raw[FP_W-2:0] < bClean.raw[FP_W-2:0];
	assign larger = bSwapped ? bClean : aClean;
	assign smaller = bSwapped ? aClean : bClean;
	assign expDiff = larger.f.exp - smaller.f.exp; // Never negative after the swap

	assign unshifted = {|smaller.f.exp, smaller.f.man, {FP_GRS_W{1'b0}}};

	always_comb begin
		// Coarse step, 0/4/8/12
		coarse = unshifted >> {expDiff[3:2], 2'b00};
		coarseLost = |(unshifted & ~({FP_EXT_W{1'b1}} << {expDiff[3:2], 2'b00}));
		// Fine step, 0 to 3
		fine = coarse >> expDiff[1:0];
		fineLost = |(coarse & ~({FP_EXT_W{1'b1}} << expDiff[1:0]));
		if (expDiff > FP_EXP_W'(FP_EXT_W - 1))
			smallMan = {{(FP_EXT_W-1){1'b0}}, |unshifted}; // Shifted past the end, sticky only
		else
			smallMan = {fine[FP_EXT_W-1:1], fine[0] | coarseLost | fineLost};
	end

endmodule

`default_nettype wire

// File: fpadd/fpNormalize.sv
`timescale 1ns/1ps
`default_nettype none

module fpNormalize
	import accumPkg::*;
(
	input logic [FP_EXT_W-1:0] bigMan,
	input logic [FP_EXT_W-1:0] smallMan,
	input logic effSub,
	output logic [FP_EXT_W:0] normMan,
	output logic [FP_SHIFT_W-1:0] shiftAmt,
	output logic zeroSum
);

	logic [FP_EXT_W:0] rawSum; // Extra top bit catches the carry
	logic [FP_SHIFT_W-1:0] leadShift;

	// bigMan is the larger magnitude, difference stays non-negative
	assign rawSum = effSub ? {1'b0, bigMan} - {1'b0, smallMan}
	                       : {1'b0, bigMan} + {1'b0, smallMan};
	assign zeroSum = ~|rawSum;

	// Priority search, highest set bit wins
	always_comb begin
		leadShift = '0;
		for (int i = 0; i < FP_EXT_W; i++) begin
			if (rawSum[i])
				leadShift = FP_SHIFT_W'(FP_EXT_W - 1 - i);
		end
	end

	always_comb begin
		if (rawSum[FP_EXT_W]) begin
			normMan = rawSum; // Carry out, rounding shifts right by one
			shiftAmt = '0;
		end else begin
			normMan = {1'b0, rawSum[FP_EXT_W-1:0] << leadShift};
			shiftAmt = leadShift;
		end
	end

endmodule

`default_nettype wire

// File: fpadd/fpRound.sv
`timescale 1ns/1ps
`default_nettype none

module fpRound
	import accumPkg::*;
(
	input logic [FP_EXT_W:0] normMan,
	input logic [FP_SHIFT_W-1:0] shiftAmt,
	input logic carryOut,
	input logic [FP_EXP_W-1:0] expIn,
	input logic signIn,
	input logic zeroSum,
	output fpHalf_u result
);

	logic [FP_EXT_W-1:0] window; // Hidden, mantissa, guard, round, sticky
	logic [FP_MAN_W-1:0] keptMan;
	logic guardBit;
	logic tailBits;
	logic roundUp;
	logic [FP_MAN_W:0] roundedMan;
	logic signed [FP_EXP_W+1:0] expAdj; // Two spare bits to spot underflow

	// Carry out moves the binary point one place left
	assign window = carryOut ? normMan[FP_EXT_W:1] : normMan[FP_EXT_W-1:0];
	assign keptMan = window[FP_EXT_W-2 -: FP_MAN_W];
	assign guardBit = window[FP_GRS_W-1];
	assign tailBits = |window[FP_GRS_W-2:0] | (carryOut & normMan[0]);

	// Nearest, ties to even
	assign roundUp = guardBit & (tailBits | keptMan[0]);
	assign roundedMan = {1'b0, keptMan} + roundUp;

	// Rounding carry leaves the fraction at zero and bumps the exponent
	assign expAdj = {2'b00, expIn} + carryOut + roundedMan[FP_MAN_W] - shiftAmt;

	always_comb begin
		result.raw = '0; // Exact zero and flushed underflow give +0
		if (!zeroSum && expAdj > 0) begin
			result.f.sign = signIn;
			result.f.exp = expAdj[FP_EXP_W-1:0];
			result.f.man = roundedMan[FP_MAN_W-1:0];
		end
	end

endmodule

`default_nettype wire

// File: fpadd/fpAdder.sv
`timescale 1ns/1ps
`default_nettype none

module fpAdder
	import accumPkg::*;
(
	input logic ap_clk,
	input fpHalf_u a,
	input fpHalf_u b,
	output fpHalf_u sum
);

	localparam int NORM_FIRST = 4;
	localparam int NORM_LAST = 6;

	fpHalf_u aQ1; // Stage 1 operands
	fpHalf_u bQ1;
	fpHalf_u largerA;
	logic [FP_EXT_W-1:0] smallA;
	logic bSwappedA;

	fpHalf_u largerQ2;
	logic [FP_EXT_W-1:0] smallQ2;
	logic swapQ2;
	logic aSignQ2;
	logic bSignQ2;

	logic [FP_EXT_W-1:0] bigQ3;
	logic [FP_EXT_W-1:0] smallQ3;
	logic effSubQ3;
	logic signQ3;
	logic [FP_EXP_W-1:0] expQ3; // Common exponent

	logic [FP_EXT_W:0] normMan;
	logic [FP_SHIFT_W-1:0] shiftAmt;
	logic zeroSum;

	// Normalize results and side data, stages 4 to 6
	logic [FP_EXT_W:0] manP [NORM_FIRST:NORM_LAST];
	logic [FP_SHIFT_W-1:0] shiftP [NORM_FIRST:NORM_LAST];
	logic [FP_EXP_W-1:0] expP [NORM_FIRST:NORM_LAST];
	logic signP [NORM_FIRST:NORM_LAST];
	logic zeroP [NORM_FIRST:NORM_LAST];

	fpHalf_u rounded;
	fpHalf_u resultQ7;

	fpAlign alignStage (
		.a(aQ1),
		.b(bQ1),
		.larger(largerA),
		.smallMan(smallA),
		.bSwapped(bSwappedA)
	);

	fpNormalize normStage (
		.bigMan(bigQ3),
		.smallMan(smallQ3),
		.effSub(effSubQ3),
		.normMan(normMan),
		.shiftAmt(shiftAmt),
		.zeroSum(zeroSum)
	);

	fpRound roundStage (
		.normMan(manP[NORM_LAST]),
		.shiftAmt(shiftP[NORM_LAST]),
		.carryOut(manP[NORM_LAST][FP_EXT_W]),
		.expIn(expP[NORM_LAST]),
		.signIn(signP[NORM_LAST]),
		.zeroSum(zeroP[NORM_LAST]),
		.result(rounded)
	);

	always_ff @(posedge ap_clk) begin
		aQ1 <= a;
		bQ1 <= b;

		// Stage 2, coarse and fine shift share the align logic ahead of it
		largerQ2 <= largerA;
		smallQ2 <= smallA;
		swapQ2 <= bSwappedA;
		aSignQ2 <= aQ1.f.sign;
		bSignQ2 <= bQ1.f.sign;

		// Stage 3, add operands and effective operation
		bigQ3 <= {|largerQ2.f.exp, largerQ2.f.man, {FP_GRS_W{1'b0}}};
		smallQ3 <= smallQ2;
		effSubQ3 <= aSignQ2 ^ bSignQ2;
		signQ3 <= swapQ2 ? bSignQ2 : aSignQ2; // Sign of the larger magnitude
		expQ3 <= largerQ2.f.exp;

		manP[NORM_FIRST] <= normMan;
		shiftP[NORM_FIRST] <= shiftAmt;
		expP[NORM_FIRST] <= expQ3;
		signP[NORM_FIRST] <= signQ3;
		zeroP[NORM_FIRST] <= zeroSum;
		// Two more slots so the add and left shift can be retimed across them
		for (int i = NORM_FIRST + 1; i <= NORM_LAST; i++) begin
			manP[i] <= manP[i-1];
			shiftP[i] <= shiftP[i-1];
			expP[i] <= expP[i-1];
			signP[i] <= signP[i-1];
			zeroP[i] <= zeroP[i-1];
		end

		resultQ7 <= rounded;
		sum <= resultQ7; // Stage 8 output register
	end

	// Known operands come out known exactly one latency later
	resultKnown: assert property (@(posedge ap_clk)
		!$isunknown({a, b}) |-> ##ADD_LATENCY !$isunknown(sum));

endmodule

`default_nettype wire

// File: logic/accumControl.sv
`timescale 1ns/1ps
`default_nettype none

module accumControl
	import accumPkg::*;
#(
	parameter int ELEM_COUNT = DEFAULT_ELEM_COUNT,
	localparam int ADDR_W = (ELEM_COUNT > 1) ? $clog2(ELEM_COUNT) : 1
) (
	input logic ap_clk,
	input logic ap_rst,
	input logic apStart,
	input logic apContinue,
	output logic apIdle,
	output logic apDone,
	output logic apReady,
	output logic [ADDR_W-1:0] memAddr,
	output logic memEnable,
	input fpHalf_u memData,
	output fpHalf_u accumOut,
	output logic accumOutValid,
	output fpHalf_u addA,
	output fpHalf_u addB,
	input fpHalf_u addSum
);

	localparam int IDX_W = $clog2(ELEM_COUNT + 1); // Must reach ELEM_COUNT itself
	localparam int WAIT_W = $clog2(ADD_LATENCY);

	typedef enum logic [1:0] {
		StIdle,
		StIssue,
		StCapture,
		StWait
	} ctrlState_e;

	ctrlState_e state;
	logic [IDX_W-1:0] elemIdx;
	logic [WAIT_W-1:0] waitCnt;
	logic doneReg; // Done held until continue
	logic startOk;
	logic finish;
	logic lastWait;
	fpHalf_u elemReg;
	fpHalf_u sumReg;
	fpHalf_u resultReg;

	assign startOk = (state == StIdle) && apStart && !doneReg;
	assign finish = (state == StIssue) && (elemIdx == IDX_W'(ELEM_COUNT));
	assign lastWait = (state == StWait) && (waitCnt == WAIT_W'(ADD_LATENCY - 1));

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= StIdle;
			elemIdx <= '0;
			waitCnt <= '0;
			doneReg <= 1'b0;
			resultReg <= '0;
		end else begin
			case (state)
				StIdle: begin
					if (startOk)
						state <= StIssue;
				end
				StIssue: state <= finish ? StIdle : StCapture;
				StCapture: begin
					state <= StWait;
					waitCnt <= '0;
				end
				StWait: begin
					waitCnt <= waitCnt + 1'b1;
					if (lastWait)
						state <= StIssue;
				end
			endcase

			if (startOk)
				elemIdx <= '0;
			else if (lastWait)
				elemIdx <= elemIdx + 1'b1;

			// Continue wins over a new done as in the block protocol
			if (apContinue)
				doneReg <= 1'b0;
			else if (finish)
				doneReg <= 1'b1;

			if (finish)
				resultReg <= sumReg;
		end
	end

	always_ff @(posedge ap_clk) begin
		if (startOk)
			sumReg <= '0;
		else if (lastWait)
			sumReg <= addSum; // Result of the add launched in the capture cycle
		if (state == StCapture)
			elemReg <= memData;
	end

	// Launch straight from memData so the result lands in the last wait cycle
	assign addA = sumReg;
	assign addB = (state == StCapture) ? memData : elemReg;

	assign memEnable = (state == StIssue) && !finish;
	assign memAddr = elemIdx[ADDR_W-1:0];

	assign apIdle = (state == StIdle) && !apStart;
	assign apDone = finish || doneReg;
	assign apReady = finish;
	assign accumOutValid = finish;
	assign accumOut = finish ? sumReg : resultReg; // Sum shows in the done cycle and then holds

	// Index never runs past the array while reads go out
	memReadInRange: assert property (@(posedge ap_clk) disable iff (ap_rst)
		memEnable |-> elemIdx < IDX_W'(ELEM_COUNT));

	// Ready comes with done and the result register keeps the sum after it
	readyHoldsDone: assert property (@(posedge ap_clk) disable iff (ap_rst)
		apReady |-> apDone ##1
			((apDone || $past(apContinue)) && accumOut == $past(accumOut)));

endmodule

`default_nettype wire

// File: logic/accumTop.sv
`timescale 1ns/1ps
`default_nettype none

module accumTop
	import accumPkg::*;
#(
	parameter int ELEM_COUNT = DEFAULT_ELEM_COUNT,
	localparam int ADDR_W = (ELEM_COUNT > 1) ? $clog2(ELEM_COUNT) : 1
) (
	input logic ap_clk,
	input logic ap_rst,
	input logic apStart,
	input logic apContinue,
	output logic apIdle,
	output logic apDone,
	output logic apReady,
	output logic [ADDR_W-1:0] memAddr,
	output logic memEnable,
	input fpHalf_u memData,
	output fpHalf_u accumOut,
	output logic accumOutValid
);

	fpHalf_u addA; // Running sum
	fpHalf_u addB; // Current element
	fpHalf_u addSum;

	accumControl #(
		.ELEM_COUNT(ELEM_COUNT)
	) control (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.apStart(apStart),
		.apContinue(apContinue),
		.apIdle(apIdle),
		.apDone(apDone),
		.apReady(apReady),
		.memAddr(memAddr),
		.memEnable(memEnable),
		.memData(memData),
		.accumOut(accumOut),
		.accumOutValid(accumOutValid),
		.addA(addA),
		.addB(addB),
		.addSum(addSum)
	);

	// Free-running pipeline, no reset
	fpAdder adder (
		.ap_clk(ap_clk),
		.a(addA),
		.b(addB),
		.sum(addSum)
	);

endmodule

`default_nettype wire

// File: test/accumTests.svh
`ifndef ACCUM_TESTS_SVH
`define ACCUM_TESTS_SVH

// Each test leaves the controller idle with done cleared

task automatic idleAfterReset();
	openTest("idleAfterReset");
	@(negedge ap_clk);
	checkBit("apIdle", 1'b1, apIdle);
	checkBit("apDone", 1'b0, apDone);
	checkBit("apReady", 1'b0, apReady);
	checkBit("accumOutValid", 1'b0, accumOutValid);
	checkBit("memEnable", 1'b0, memEnable);
	checkHalf("accumOut", 16'h0000, accumOut);
	closeTest();
endtask

task automatic sumOfIntegers();
	fpHalf_u result;
	int doneCycle;
	openTest("sumOfIntegers");
	mem = '{16'h3C00, 16'h4000, 16'h4200, 16'h4400, // 1 to 4
		16'h4500, 16'h4600, 16'h4700, 16'h4800}; // 5 to 8
	runAccumulation(result, doneCycle);
	if (doneCycle != DONE_CYCLE)
		reportFailure($sformatf("done pulse in cycle %0d, not %0d", doneCycle, DONE_CYCLE));
	checkBit("apDone in done cycle", 1'b1, apDone);
	checkBit("apReady in done cycle", 1'b1, apReady);
	checkBit("accumOutValid in done cycle", 1'b1, accumOutValid);
	checkHalf("sum", 16'h5080, result); // 36.0
	giveContinue();
	closeTest();
endtask

task automatic exactMixedSigns();
	fpHalf_u result;
	int doneCycle;
	openTest("exactMixedSigns");
	// 2.5 -0.75 4 -1.25 0.5 3 -2 0.125
	mem = '{16'h4100, 16'hBA00, 16'h4400, 16'hBD00,
		16'h3800, 16'h4200, 16'hC000, 16'h3000};
	runAccumulation(result, doneCycle);
	checkHalf("mixed sum", 16'h4620, result); // 6.125
	giveContinue();
	// 1.5 -1.5 3.25 -3.25 0.5 -0.25 -0.25, then -0
	mem = '{16'h3E00, 16'hBE00, 16'h4280, 16'hC280,
		16'h3800, 16'hB400, 16'hB400, 16'h8000};
	runAccumulation(result, doneCycle);
	checkHalf("cancelled sum", 16'h0000, result); // Positive zero
	giveContinue();
	closeTest();
endtask

task automatic randomOperands();
	fpHalf_u result;
	fpHalf_u expected;
	logic [15:0] signBit;
	logic [15:0] expBits;
	logic [15:0] manBits;
	int doneCycle;
	openTest("randomOperands");
	for (int run = 0; run < 2; run++) begin
		for (int i = 0; i < ELEM_COUNT; i++) begin
			takeRandomBits(1, signBit);
			takeRandomBits(3, expBits);
			takeRandomBits(10, manBits);
			// Exponent fields 12 to 19, sums stay normal and far from overflow
			mem[i] = {signBit[0], 5'd12 + {2'b00, expBits[2:0]}, manBits[9:0]};
		end
		expected = referenceSum();
		runAccumulation(result, doneCycle);
		checkHalf($sformatf("random sum, run %0d", run), expected, result);
		giveContinue();
	end
	closeTest();
endtask

task automatic doneHoldsUntilContinue();
	fpHalf_u result;
	fpHalf_u expected;
	int doneCycle;
	int waited;
	openTest("doneHoldsUntilContinue");
	mem = '{16'h3C00, 16'h2E66, 16'h4248, 16'hC100,
		16'h3800, 16'h4B00, 16'hB666, 16'h3001};
	expected = referenceSum();
	runAccumulation(result, doneCycle);
	checkHalf("sum", expected, result);
	repeat (4) begin
		@(negedge ap_clk);
		checkBit("apDone held", 1'b1, apDone);
		checkBit("apReady after done cycle", 1'b0, apReady);
		checkBit("accumOutValid after done cycle", 1'b0, accumOutValid);
		checkHalf("accumOut held", expected, accumOut);
	end
	readLog.delete();
	apStart = 1'b1; // Start while done is held
	repeat (6) begin
		@(negedge ap_clk);
		checkBit("memEnable while done held", 1'b0, memEnable);
		checkBit("apDone with start pending", 1'b1, apDone);
		checkBit("apIdle with start high", 1'b0, apIdle);
	end
	if (readLog.size() != 0)
		reportFailure("memory read while done was held");
	apContinue = 1'b1;
	@(negedge ap_clk);
	apContinue = 1'b0;
	checkHalf("accumOut after continue", expected, accumOut);
	waited = 0;
	while (!memEnable && waited < 4) begin
		@(negedge ap_clk);
		waited++;
	end
	apStart = 1'b0;
	if (!memEnable) begin
		reportFailure("held start not accepted after continue");
	end else begin
		checkAddr("first address after restart", '0, memAddr);
		waitForDone(doneCycle);
		checkHalf("sum after restart", expected, accumOut);
		giveContinue();
	end
	closeTest();
endtask

task automatic backToBackRuns();
	fpHalf_u result;
	fpHalf_u expected;
	int doneCycle;
	openTest("backToBackRuns");
	mem = '{16'h3C01, 16'h4123, 16'h3E9A, 16'hC0F0,
		16'h4A00, 16'h3555, 16'hB9C0, 16'h4404};
	expected = referenceSum();
	runAccumulation(result, doneCycle);
	checkHalf("first run sum", expected, result);
	checkReadOrder();
	giveContinue();
	// -0.5 20 -5 0.75 100 -1 10 0.0625
	mem = '{16'hB800, 16'h4D00, 16'hC500, 16'h3A00,
		16'h5640, 16'hBC00, 16'h4900, 16'h2C00};
	expected = referenceSum(); // From zero, not from the first total
	runAccumulation(result, doneCycle);
	checkHalf("second run sum", expected, result);
	checkReadOrder();
	giveContinue();
	closeTest();
endtask

`endif

// File: test/accumTb.sv
`timescale 1ns/1ps
`default_nettype none

module accumTb
	import accumPkg::*;
();

	localparam int ELEM_COUNT = 8;
	localparam int ADDR_W = (ELEM_COUNT > 1) ? $clog2(ELEM_COUNT) : 1;
	localparam int DONE_CYCLE = ELEM_COUNT * (2 + ADD_LATENCY) + 1; // Issue, capture, wait per element
	localparam int RUN_LIMIT = DONE_CYCLE + 40;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 200;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES;

	logic ap_clk;
	logic ap_rst;
	logic apStart;
	logic apContinue;
	logic apIdle;
	logic apDone;
	logic apReady;
	logic [ADDR_W-1:0] memAddr;
	logic memEnable;
	fpHalf_u memData;
	fpHalf_u accumOut;
	logic accumOutValid;

	logic [FP_W-1:0] mem [ELEM_COUNT]; // Word memory behind the read port
	logic readPending = 1'b0;
	logic [ADDR_W-1:0] readAddr = '0;
	logic [ADDR_W-1:0] readLog [$]; // Addresses read in the current run

	int errorCount = 0;
	int failedTests = 0;
	int testsRun = 0;
	int testStartErrors = 0;
	int cycleCount = 0;
	string testName = "none";
	logic [31:0] lfsrState = 32'h425d;

	accumTop #(
		.ELEM_COUNT(ELEM_COUNT)
	) DUT (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.apStart(apStart),
		.apContinue(apContinue),
		.apIdle(apIdle),
		.apDone(apDone),
		.apReady(apReady),
		.memAddr(memAddr),
		.memEnable(memEnable),
		.memData(memData),
		.accumOut(accumOut),
		.accumOutValid(accumOutValid)
	);

	initial begin
		ap_clk = 1'b0;
		forever #4 ap_clk = ~ap_clk; // 8 ns period
	end

	// One-cycle memory, answers on the falling edge after the read
	always @(negedge ap_clk) begin
		if (readPending)
			memData = mem[readAddr];
		readPending = memEnable;
		readAddr = memAddr;
		if (memEnable)
			readLog.push_back(memAddr);
	end

	always @(posedge ap_clk) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: simulation ran %0d cycles without finishing", cycleCount);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic openTest(input string name);
		testName = name;
		testStartErrors = errorCount;
		testsRun++;
	endtask

	task automatic closeTest();
		if (errorCount == testStartErrors) begin
			$display("%s: passed", testName);
		end else begin
			$display("%s: failed, %0d errors", testName, errorCount - testStartErrors);
			failedTests++;
		end
	endtask

	task automatic reportFailure(input string msg);
		$display("Error in %s: %s", testName, msg);
		errorCount++;
	endtask

	task automatic checkHalf(input string what, input fpHalf_u expected, input fpHalf_u actual);
		if (actual.raw !== expected.raw) begin
			$display("Mismatch in %s, %s: expected %h, actual %h",
				testName, what, expected.raw, actual.raw);
			errorCount++;
		end
	endtask

	task automatic checkBit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Mismatch in %s, %s: expected %b, actual %b",
				testName, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkAddr(input string what, input logic [ADDR_W-1:0] expected,
			input logic [ADDR_W-1:0] actual);
		if (actual !== expected) begin
			$display("Mismatch in %s, %s: expected %0d, actual %0d",
				testName, what, expected, actual);
			errorCount++;
		end
	endtask

	function automatic real pow2(input int e);
		real p;
		p = 1.0;
		if (e >= 0) begin
			for (int i = 0; i < e; i++)
				p = p * 2.0;
		end else begin
			for (int i = 0; i < -e; i++)
				p = p / 2.0;
		end
		return p;
	endfunction

	// Zero exponent field reads as zero, no subnormals
	function automatic real halfToReal(input fpHalf_u h);
		real mag;
		if (h.f.exp == '0)
			return 0.0;
		mag = (1.0 + h.f.man / 1024.0) * pow2(int'(h.f.exp) - FP_BIAS);
		return h.f.sign ? -mag : mag;
	endfunction

	// Nearest, ties to even; results below the normal range flush to +0
	function automatic fpHalf_u realToHalf(input real value);
		fpHalf_u h;
		real mag;
		real scaled;
		real frac;
		int e;
		int man;
		int expField;
		h.raw = '0;
		if (value == 0.0)
			return h;
		mag = (value < 0.0) ? -value : value;
		e = 0;
		while (mag >= pow2(e + 1))
			e++;
		while (mag < pow2(e))
			e--;
		scaled = mag / pow2(e - FP_MAN_W); // Lands in [1024, 2048)
		man = int'(scaled);
		if (real'(man) > scaled)
			man = man - 1; // Floor
		frac = scaled - real'(man);
		if (frac > 0.5 || (frac == 0.5 && man % 2 == 1))
			man = man + 1;
		if (man == 2048) begin
			man = 1024;
			e++;
		end
		expField = e + FP_BIAS;
		if (expField <= 0)
			return h;
		h.f.sign = (value < 0.0);
		h.f.exp = expField[FP_EXP_W-1:0];
		h.f.man = FP_MAN_W'(man - 1024);
		return h;
	endfunction

	// Sum from zero, rounded after each element in index order
	function automatic fpHalf_u referenceSum();
		fpHalf_u acc;
		acc.raw = '0;
		for (int i = 0; i < ELEM_COUNT; i++)
			acc = realToHalf(halfToReal(acc) + halfToReal(mem[i]));
		return acc;
	endfunction

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // Galois form
	endfunction

	task automatic takeRandomBits(input int count, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[14:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	// Counts falling edges from cycle 1 until the valid pulse
	task automatic waitForDone(output int cycles);
		cycles = 1;
		while (!accumOutValid && cycles < RUN_LIMIT) begin
			@(negedge ap_clk);
			cycles++;
		end
		if (!accumOutValid)
			reportFailure($sformatf("no done pulse within %0d cycles", RUN_LIMIT));
	endtask

	// Returns at the falling edge of the done cycle
	task automatic runAccumulation(output fpHalf_u result, output int doneCycle);
		@(negedge ap_clk);
		if (!apIdle || apDone)
			reportFailure("controller not idle, or done still held, before start");
		readLog.delete();
		apStart = 1'b1;
		@(negedge ap_clk); // Accepting edge just passed
		apStart = 1'b0;
		waitForDone(doneCycle);
		result = accumOut;
	endtask

	task automatic giveContinue();
		@(negedge ap_clk);
		apContinue = 1'b1;
		@(negedge ap_clk);
		apContinue = 1'b0;
		checkBit("apDone after continue", 1'b0, apDone);
	endtask

	task automatic checkReadOrder();
		if (readLog.size() != ELEM_COUNT) begin
			reportFailure($sformatf("%0d memory reads in the run, expected %0d",
				readLog.size(), ELEM_COUNT));
		end else begin
			for (int i = 0; i < ELEM_COUNT; i++)
				checkAddr("read address", ADDR_W'(i), readLog[i]);
		end
	endtask

	`include "accumTests.svh"

	initial begin
		ap_rst = 1'b1;
		apStart = 1'b0;
		apContinue = 1'b0;
		memData = '0;
		for (int i = 0; i < ELEM_COUNT; i++)
			mem[i] = '0;
		repeat (RESET_CYCLES) @(posedge ap_clk);
		@(negedge ap_clk);
		ap_rst = 1'b0;

		idleAfterReset();
		sumOfIntegers();
		exactMixedSigns();
		randomOperands();
		doneHoldsUntilContinue();
		backToBackRuns();

		$display("%0d tests run, %0d failed, %0d errors", testsRun, failedTests, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+test
common/accumPkg.sv
fpadd/fpAlign.sv
fpadd/fpNormalize.sv
fpadd/fpRound.sv
fpadd/fpAdder.sv
logic/accumControl.sv
logic/accumTop.sv
test/accumTb.sv
